//--- gpu_cmd_top.f
+incdir+tb
hw/gpu_cmd_pkg.sv
hw/cmd_intake.sv
hw/cmd_fifo.sv
hw/reg_file.sv
hw/gpu_cmd_top.sv
tb/tb_gpu_cmd_top.sv

//--- hw/cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo #(
    parameter int DEPTH     = 16,
    parameter int NEAR_FULL = 12
) (
    input  logic                       clk_core,
    input  logic                       rst_n_core,

    // Write side
    input  logic                       push,
    input  gpu_cmd_pkg::cmd_t          push_data,
    output logic                       full,
    output logic                       near_full,

    // Read side, first-word fall-through
    input  logic                       pop,
    output gpu_cmd_pkg::cmd_t          head,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    import gpu_cmd_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset on the payload
    logic [CMD_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Qualified strobes
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ========================================================================
    // Pointers and occupancy
    // ========================================================================

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_core) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head is visible the cycle after its push
    assign head = cmd_t'(mem[rd_ptr]);

    // Flags from the registered count
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign near_full = (count >= CNT_W'(NEAR_FULL));

    // Intake must respect full
    no_push_when_full: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        push |-> !full
    ) else $error("push while FIFO full");

    // Register file must respect empty
    no_pop_when_empty: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        pop |-> !empty
    ) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

//--- hw/cmd_intake.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_intake (
    input  logic              clk_core,
    input  logic              rst_n_core,

    // Host command port, four-phase
    input  logic              cmd_req,
    input  gpu_cmd_pkg::cmd_t cmd,
    output logic              cmd_ack,

    // FIFO write side
    output logic              push,
    output gpu_cmd_pkg::cmd_t push_data,
    input  logic              fifo_full
);

    // IDLE waits for req, ACKED holds ack until req drops
    typedef enum logic {
        IDLE,
        ACKED
    } intake_state_e;

    intake_state_e state;
    intake_state_e state_nxt;

    // ========================================================================
    // Handshake FSM
    // ========================================================================

    always_comb begin
        state_nxt = state;
        push      = 1'b0;
        case (state)
            IDLE: begin
                // Host holds cmd stable while req is high
                // Stall here as long as the FIFO is full
                if (cmd_req && !fifo_full) begin
                    push      = 1'b1;
                    state_nxt = ACKED;
                end
            end
            ACKED: begin
                // Release ack once host lets go of req
                if (!cmd_req) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Command goes straight into the FIFO
    assign push_data = cmd;

    // Ack follows the state register, one cycle after the push
    assign cmd_ack = (state == ACKED);

    // Every rising ack belongs to exactly one push
    ack_after_push: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        $rose(cmd_ack) |-> $past(push)
    ) else $error("cmd_ack rose without a FIFO push");

endmodule

`default_nettype wire

//--- hw/gpu_cmd_pkg.sv
package gpu_cmd_pkg;

    // ========================================================================
    // Host command format
    // ========================================================================

    // Width of one queued command word
    localparam int CMD_W = 72;

    // rw high reads, rw low writes
    typedef struct packed {
        logic        rw;
        logic [6:0]  addr;
        logic [63:0] wdata;
    } cmd_t;

    // Register map
    typedef enum logic [6:0] {
        REG_COLOR      = 7'h00,
        REG_MODE       = 7'h30,
        REG_Z_RANGE    = 7'h31,
        REG_FB_DRAW    = 7'h40,
        REG_FB_DISPLAY = 7'h41,
        REG_TS         = 7'h50,
        REG_STATUS     = 7'h70
    } reg_addr_e;

    // ========================================================================
    // Render configuration
    // ========================================================================

    // Depth test functions, LESS is the reset value
    typedef enum logic [2:0] {
        LESS     = 3'd0,
        LEQUAL   = 3'd1,
        EQUAL    = 3'd2,
        GEQUAL   = 3'd3,
        GREATER  = 3'd4,
        NOTEQUAL = 3'd5,
        ALWAYS   = 3'd6,
        NEVER    = 3'd7
    } z_compare_e;

    // Everything the render pipe reads from the register file
    typedef struct packed {
        logic        mode_gouraud;
        logic        mode_z_test;
        logic        mode_z_write;
        logic        mode_color_write;
        z_compare_e  z_compare;
        logic [15:0] z_range_min;
        logic [15:0] z_range_max;
        logic [19:0] fb_draw;
        logic [19:0] fb_display;
        logic [31:0] clear_color;
    } gpu_cfg_t;

    // Single-word memory write, half-word addressed
    typedef struct packed {
        logic [23:0] addr;
        logic [31:0] data;
    } mem_wr_t;

endpackage

//--- hw/gpu_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module gpu_cmd_top #(
    parameter int DEPTH     = 16,
    parameter int NEAR_FULL = 12
) (
    input  logic                  clk_core,
    input  logic                  rst_n_core,

    // Host command port
    input  logic                  cmd_req,
    input  gpu_cmd_pkg::cmd_t     cmd,
    output logic                  cmd_ack,

    // Register read port
    output logic                  rd_valid,
    output logic [63:0]           rd_data,

    // Timestamp memory port
    output logic                  mem_req,
    output gpu_cmd_pkg::mem_wr_t  mem_wr,
    input  logic                  mem_ack,

    // Status and configuration
    output logic                  cmd_near_full,
    output logic                  cmd_empty,
    output gpu_cmd_pkg::gpu_cfg_t cfg
);

    import gpu_cmd_pkg::*;

    // Count must hold the value DEPTH
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ========================================================================
    // Intake to FIFO
    // ========================================================================

    logic push;
    cmd_t push_data;
    logic fifo_full;

    // FIFO to register file
    logic             pop;
    cmd_t             head;
    logic [CNT_W-1:0] count;

    cmd_intake u_cmd_intake (
        .clk_core  (clk_core),
        .rst_n_core(rst_n_core),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .push      (push),
        .push_data (push_data),
        .fifo_full (fifo_full)
    );

    cmd_fifo #(
        .DEPTH    (DEPTH),
        .NEAR_FULL(NEAR_FULL)
    ) u_cmd_fifo (
        .clk_core  (clk_core),
        .rst_n_core(rst_n_core),
        .push      (push),
        .push_data (push_data),
        .full      (fifo_full),
        .near_full (cmd_near_full),
        .pop       (pop),
        .head      (head),
        .empty     (cmd_empty),
        .count     (count)
    );

    // ========================================================================
    // Command decode
    // ========================================================================

    reg_file #(
        .CNT_W(CNT_W)
    ) u_reg_file (
        .clk_core  (clk_core),
        .rst_n_core(rst_n_core),
        .pop       (pop),
        .head      (head),
        .empty     (cmd_empty),
        .count     (count),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .cfg       (cfg),
        .mem_req   (mem_req),
        .mem_wr    (mem_wr),
        .mem_ack   (mem_ack)
    );

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int CNT_W = 5
) (
    input  logic                   clk_core,
    input  logic                   rst_n_core,

    // FIFO read side
    output logic                   pop,
    input  gpu_cmd_pkg::cmd_t      head,
    input  logic                   empty,
    input  logic [CNT_W-1:0]       count,

    // Register read port
    output logic                   rd_valid,
    output logic [63:0]            rd_data,

    // Render configuration
    output gpu_cmd_pkg::gpu_cfg_t  cfg,

    // Timestamp memory write, four-phase
    output logic                   mem_req,
    output gpu_cmd_pkg::mem_wr_t   mem_wr,
    input  logic                   mem_ack
);

    import gpu_cmd_pkg::*;

    // DECODE consumes commands, the other two walk the memory handshake
    typedef enum logic [1:0] {
        DECODE,
        MEM_REQ,
        MEM_RELEASE
    } rf_state_e;

    rf_state_e   state;
    reg_addr_e   addr;
    logic        is_read;
    logic        ts_write;
    logic [63:0] rd_mux;

    // Pop only while no memory handshake is open
    assign pop = (state == DECODE) && !empty;

    assign addr     = reg_addr_e'(head.addr);
    assign is_read  = head.rw;
    assign ts_write = pop && !is_read && (addr == REG_TS);

    // Request held for the whole MEM_REQ state
    assign mem_req = (state == MEM_REQ);

    // ========================================================================
    // Readback mux
    // ========================================================================

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_COLOR: begin
                rd_mux = {32'd0, cfg.clear_color};
            end
            REG_MODE: begin
                // Mode word layout, bit 6 down to bit 0
                rd_mux = {57'd0, cfg.mode_gouraud, cfg.mode_z_test, cfg.mode_z_write,
                          cfg.mode_color_write, cfg.z_compare};
            end
            REG_Z_RANGE: begin
                rd_mux = {32'd0, cfg.z_range_max, cfg.z_range_min};
            end
            REG_FB_DRAW: begin
                rd_mux = {44'd0, cfg.fb_draw};
            end
            REG_FB_DISPLAY: begin
                rd_mux = {44'd0, cfg.fb_display};
            end
            REG_STATUS: begin
                // Entries still queued behind this read
                rd_mux = 64'(count - 1'b1);
            end
            // TS is write only, unmapped reads as zero
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // ========================================================================
    // Decode FSM and configuration registers
    // ========================================================================

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            state    <= DECODE;
            cfg      <= '0;
            rd_valid <= 1'b0;
        end else begin
            // One-cycle strobe per read
            rd_valid <= pop && is_read;
            case (state)
                DECODE: begin
                    if (pop && !is_read) begin
                        case (addr)
                            REG_COLOR: begin
                                cfg.clear_color <= head.wdata[31:0];
                            end
                            REG_MODE: begin
                                cfg.mode_gouraud     <= head.wdata[6];
                                cfg.mode_z_test      <= head.wdata[5];
                                cfg.mode_z_write     <= head.wdata[4];
                                cfg.mode_color_write <= head.wdata[3];
                                cfg.z_compare        <= z_compare_e'(head.wdata[2:0]);
                            end
                            REG_Z_RANGE: begin
                                cfg.z_range_min <= head.wdata[15:0];
                                cfg.z_range_max <= head.wdata[31:16];
                            end
                            REG_FB_DRAW: begin
                                cfg.fb_draw <= head.wdata[19:0];
                            end
                            REG_FB_DISPLAY: begin
                                cfg.fb_display <= head.wdata[19:0];
                            end
                            REG_TS: begin
                                state <= MEM_REQ;
                            end
                            // Status and unmapped writes dropped
                            default: begin
                            end
                        endcase
                    end
                end
                MEM_REQ: begin
                    // Drop req once memory has taken the write
                    if (mem_ack) begin
                        state <= MEM_RELEASE;
                    end
                end
                MEM_RELEASE: begin
                    // Resume decoding after ack returns low
                    if (!mem_ack) begin
                        state <= DECODE;
                    end
                end
                default: begin
                    state <= DECODE;
                end
            endcase
        end
    end

    // Read data and memory request payload
    always_ff @(posedge clk_core) begin
        if (pop && is_read) begin
            rd_data <= rd_mux;
        end
        if (ts_write) begin
            // Word address doubled to half-word
            mem_wr.addr <= {head.wdata[54:32], 1'b0};
            mem_wr.data <= head.wdata[31:0];
        end
    end

    // Payload must not move under an open request
    mem_wr_stable: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        mem_req && $past(mem_req) |-> $stable(mem_wr)
    ) else $error("mem_wr changed while mem_req high");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_gpu_cmd_top \
    -f gpu_cmd_top.f -o sim_gpu_cmd_top || exit 1
sim_out=$(./obj_dir/sim_gpu_cmd_top)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Done: no errors" && exit 0 || exit 1

//--- tb/tb_tests.svh
// ============================================================================
// Reset and register access
// ============================================================================

task automatic test_reset_state();
    if (cmd_empty !== 1'b1)
        log_mismatch("cmd_empty not high after reset");
    if (cmd_near_full !== 1'b0)
        log_mismatch("cmd_near_full not low after reset");
    if (mem_req !== 1'b0)
        log_mismatch("mem_req not low after reset");
    if (rd_valid !== 1'b0)
        log_mismatch("rd_valid not low after reset");
    if (cmd_ack !== 1'b0)
        log_mismatch("cmd_ack not low after reset");
    // All zero, so depth compare is LESS
    if (cfg !== '0)
        log_mismatch($sformatf("cfg after reset is %h, expected zero", cfg));
endtask

// Write, then read back through the FIFO so the write has landed
task automatic write_then_read(input logic [6:0] addr, input logic [63:0] wdata,
                               output logic [63:0] rdata);
    send_cmd(1'b0, addr, wdata);
    read_reg(addr, rdata);
endtask

task automatic test_reg_readback();
    logic [63:0] wdata;
    logic [63:0] rdata;
    int          i;
    // Clear color, low 32 bits
    wdata = {$random(seed), $random(seed)};
    write_then_read(REG_COLOR, wdata, rdata);
    if (cfg.clear_color !== wdata[31:0])
        log_mismatch($sformatf("clear_color %h, expected %h", cfg.clear_color, wdata[31:0]));
    if (rdata !== {32'd0, wdata[31:0]})
        log_mismatch($sformatf("REG_COLOR read %h, wrote %h", rdata, wdata));
    // Mode word, every depth compare function
    for (i = 0; i < 8; i++) begin
        wdata      = {$random(seed), $random(seed)};
        wdata[2:0] = i[2:0];
        write_then_read(REG_MODE, wdata, rdata);
        if (cfg.z_compare !== z_compare_e'(i[2:0]))
            log_mismatch($sformatf("z_compare %0d, expected %0d", cfg.z_compare, i));
        if ({cfg.mode_gouraud, cfg.mode_z_test, cfg.mode_z_write,
             cfg.mode_color_write} !== wdata[6:3])
            log_mismatch($sformatf("mode bits wrong for mode word %h", wdata));
        if (rdata !== {57'd0, wdata[6:0]})
            log_mismatch($sformatf("REG_MODE read %h, wrote %h", rdata, wdata));
    end
    // Depth range, min low and max high
    wdata = {$random(seed), $random(seed)};
    write_then_read(REG_Z_RANGE, wdata, rdata);
    if (cfg.z_range_min !== wdata[15:0] || cfg.z_range_max !== wdata[31:16])
        log_mismatch($sformatf("z range %h/%h from %h", cfg.z_range_min,
                               cfg.z_range_max, wdata));
    if (rdata !== {32'd0, wdata[31:0]})
        log_mismatch($sformatf("REG_Z_RANGE read %h, wrote %h", rdata, wdata));
    // Framebuffer bases, 20 bits
    wdata = {$random(seed), $random(seed)};
    write_then_read(REG_FB_DRAW, wdata, rdata);
    if (cfg.fb_draw !== wdata[19:0] || rdata !== {44'd0, wdata[19:0]})
        log_mismatch($sformatf("fb_draw %h, read %h, wrote %h", cfg.fb_draw, rdata, wdata));
    wdata = {$random(seed), $random(seed)};
    write_then_read(REG_FB_DISPLAY, wdata, rdata);
    if (cfg.fb_display !== wdata[19:0] || rdata !== {44'd0, wdata[19:0]})
        log_mismatch($sformatf("fb_display %h, read %h, wrote %h", cfg.fb_display,
                               rdata, wdata));
endtask

task automatic test_status_unmapped();
    gpu_cfg_t    saved;
    logic [63:0] rdata;
    // Nothing queued behind the status read
    read_reg(REG_STATUS, rdata);
    if (rdata !== 64'd0)
        log_mismatch($sformatf("REG_STATUS read %h with FIFO empty", rdata));
    read_reg(7'h12, rdata);
    if (rdata !== 64'd0)
        log_mismatch($sformatf("unmapped 0x12 read %h", rdata));
    read_reg(7'h7f, rdata);
    if (rdata !== 64'd0)
        log_mismatch($sformatf("unmapped 0x7f read %h", rdata));
    // Writes that must be dropped
    saved = cfg;
    send_cmd(1'b0, 7'h12, {$random(seed), $random(seed)});
    send_cmd(1'b0, 7'h7f, {$random(seed), $random(seed)});
    send_cmd(1'b0, REG_STATUS, {$random(seed), $random(seed)});
    read_reg(REG_STATUS, rdata);
    if (cfg !== saved)
        log_mismatch("cfg changed after unmapped or read-only writes");
endtask

// ============================================================================
// Timestamp handshake and back-pressure
// ============================================================================

task automatic test_timestamp();
    logic [22:0] word_addr;
    logic [31:0] ts_data;
    logic [31:0] old_color;
    logic [31:0] new_color;
    logic [23:0] exp_addr;
    int          done_before;
    int          n;
    word_addr   = 23'($random(seed));
    ts_data     = $random(seed);
    new_color   = $random(seed);
    old_color   = cfg.clear_color;
    if (new_color == old_color)
        new_color = ~old_color;
    // Half-word address is twice the word address
    exp_addr    = {1'b0, word_addr} * 24'd2;
    done_before = ts_done;
    mem_delay   = 10;
    send_cmd(1'b0, REG_TS, {9'd0, word_addr, ts_data});
    send_cmd(1'b0, REG_COLOR, {32'd0, new_color});
    if (!mem_req)
        log_failure("mem_req not open while color write was queued behind it");
    // Color write stuck behind the open handshake
    n = 0;
    while (ts_done == done_before && n < WAIT_MAX) begin
        if (cfg.clear_color !== old_color)
            log_mismatch("color applied while timestamp handshake was open");
        next_cycle();
        n++;
    end
    if (ts_done == done_before)
        log_failure("timestamp handshake did not complete");
    if (ts_wr.addr !== exp_addr)
        log_mismatch($sformatf("mem_wr.addr %h, expected %h", ts_wr.addr, exp_addr));
    if (ts_wr.data !== ts_data)
        log_mismatch($sformatf("mem_wr.data %h, expected %h", ts_wr.data, ts_data));
    n = 0;
    while (cfg.clear_color !== new_color && n < WAIT_MAX) begin
        next_cycle();
        n++;
    end
    if (cfg.clear_color !== new_color)
        log_mismatch($sformatf("clear_color %h after handshake, expected %h",
                               cfg.clear_color, new_color));
endtask

task automatic test_back_pressure();
    logic [31:0] colors [DEPTH+1];
    logic [31:0] seen;
    logic        near_exp;
    int          i;
    int          n;
    int          idx;
    mem_delay = 2;
    mem_stall = 1'b1;
    send_cmd(1'b0, REG_TS, {$random(seed), $random(seed)});
    n = 0;
    while (!mem_req && n < WAIT_MAX) begin
        next_cycle();
        n++;
    end
    if (!mem_req)
        log_failure("mem_req did not rise for the stalled timestamp write");
    // Index in the top byte keeps the values distinct
    for (i = 0; i <= DEPTH; i++)
        colors[i] = {i[7:0], 24'($random(seed))};
    for (i = 0; i < DEPTH; i++) begin
        send_cmd(1'b0, REG_COLOR, {32'd0, colors[i]});
        near_exp = (i + 1 >= NEAR_FULL);
        if (cmd_near_full !== near_exp)
            log_mismatch($sformatf("cmd_near_full %b with %0d queued", cmd_near_full, i + 1));
    end
    // FIFO full, this one must wait
    cmd.rw    = 1'b0;
    cmd.addr  = REG_COLOR;
    cmd.wdata = {32'd0, colors[DEPTH]};
    cmd_req   = 1'b1;
    for (n = 0; n < 10; n++) begin
        next_cycle();
        if (cmd_ack)
            log_mismatch("cmd_ack given while FIFO full");
    end
    // Release memory, finish the withheld handshake, watch the drain order
    seen      = cfg.clear_color;
    idx       = 0;
    mem_stall = 1'b0;
    n = 0;
    while (n < WAIT_MAX && !(idx == DEPTH + 1 && cmd_empty && !cmd_req && !cmd_ack)) begin
        next_cycle();
        n++;
        if (cmd_req && cmd_ack)
            cmd_req = 1'b0;
        if (cfg.clear_color !== seen) begin
            if (idx > DEPTH || cfg.clear_color !== colors[idx])
                log_mismatch($sformatf("clear_color %h out of order at write %0d",
                                       cfg.clear_color, idx));
            else
                idx++;
            seen = cfg.clear_color;
        end
    end
    if (cmd_req || cmd_ack)
        log_failure("withheld command handshake did not finish");
    if (idx != DEPTH + 1)
        log_mismatch($sformatf("%0d of %0d queued writes applied", idx, DEPTH + 1));
    if (!cmd_empty || cmd_near_full)
        log_mismatch("FIFO flags wrong after draining");
    if (cfg.clear_color !== colors[DEPTH])
        log_mismatch($sformatf("final clear_color %h, expected %h", cfg.clear_color,
                               colors[DEPTH]));
endtask

//--- tb/tb_gpu_cmd_top.sv
`timescale 1ns/1ns

module tb_gpu_cmd_top;

    import gpu_cmd_pkg::*;

    localparam int DEPTH     = 16;
    localparam int NEAR_FULL = 12;
    // Cycle limit for every wait loop
    localparam int WAIT_MAX  = 200;

    logic        clk_core;
    logic        rst_n_core;
    logic        cmd_req;
    cmd_t        cmd;
    logic        cmd_ack;
    logic        rd_valid;
    logic [63:0] rd_data;
    logic        mem_req;
    mem_wr_t     mem_wr;
    logic        mem_ack;
    logic        cmd_near_full;
    logic        cmd_empty;
    gpu_cfg_t    cfg;

    // Error counts and random seed
    int          mismatch_count;
    int          failure_count;
    integer      seed;

    // Memory responder control and capture
    int          mem_delay;
    logic        mem_stall;
    logic        ts_seen;
    int          ts_wait;
    int          ts_done;
    mem_wr_t     ts_wr;

    // Read data from each rd_valid pulse
    logic [63:0] rd_q[$];

    gpu_cmd_top #(
        .DEPTH    (DEPTH),
        .NEAR_FULL(NEAR_FULL)
    ) dut (
        .clk_core     (clk_core),
        .rst_n_core   (rst_n_core),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .cmd_ack      (cmd_ack),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_ack      (mem_ack),
        .cmd_near_full(cmd_near_full),
        .cmd_empty    (cmd_empty),
        .cfg          (cfg)
    );

    // 8 ns clock
    initial begin
        clk_core = 1'b0;
        forever #4 clk_core = ~clk_core;
    end

    // ========================================================================
    // Driver and report helpers
    // ========================================================================

    // Drive and sample point, 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_core);
        #1;
    endtask

    task automatic log_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        failure_count++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // Full four-phase host handshake
    task automatic send_cmd(input logic rw, input logic [6:0] addr, input logic [63:0] wdata);
        int n;
        cmd.rw    = rw;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd_req   = 1'b1;
        n = 0;
        while (!cmd_ack && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (!cmd_ack)
            log_failure($sformatf("gave up waiting for cmd_ack on address %h", addr));
        cmd_req = 1'b0;
        n = 0;
        while (cmd_ack && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (cmd_ack)
            log_failure("cmd_ack stayed high after cmd_req dropped");
    endtask

    // Read command, then wait for the captured read data
    task automatic read_reg(input logic [6:0] addr, output logic [63:0] data);
        int n;
        rd_q.delete();
        send_cmd(1'b1, addr, 64'd0);
        n = 0;
        while (rd_q.size() == 0 && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (rd_q.size() == 0) begin
            log_failure($sformatf("no rd_valid pulse for read of address %h", addr));
            data = '0;
        end else begin
            data = rd_q.pop_front();
        end
    endtask

    // rd_valid is a one-cycle strobe
    initial begin
        forever begin
            next_cycle();
            if (rd_valid)
                rd_q.push_back(rd_data);
        end
    end

    // ========================================================================
    // Memory responder
    // ========================================================================

    // Acks mem_delay cycles after req unless stalled
    // Ack held the same number of cycles after req falls
    initial begin
        forever begin
            next_cycle();
            if (mem_req && !mem_ack) begin
                if (!ts_seen) begin
                    ts_seen = 1'b1;
                    ts_wr   = mem_wr;
                    ts_wait = 0;
                end
                if (!mem_stall) begin
                    if (ts_wait >= mem_delay)
                        mem_ack = 1'b1;
                    else
                        ts_wait++;
                end
            end else if (!mem_req && mem_ack) begin
                // Late release shows any decode before ack falls
                if (ts_wait > 0) begin
                    ts_wait--;
                end else begin
                    mem_ack = 1'b0;
                    ts_seen = 1'b0;
                    ts_done++;
                end
            end else if (!mem_req && ts_seen) begin
                log_failure("mem_req dropped before mem_ack was given");
                ts_seen = 1'b0;
            end
        end
    end

    `include "tb_tests.svh"

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        rst_n_core     = 1'b0;
        cmd_req        = 1'b0;
        cmd            = '0;
        mem_ack        = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        seed           = 32'hcde6_1eca;
        mem_delay      = 3;
        mem_stall      = 1'b0;
        ts_seen        = 1'b0;
        ts_wait        = 0;
        ts_done        = 0;
        ts_wr          = '0;
        // Two cycles of reset
        repeat (2) @(posedge clk_core);
        #1;
        rst_n_core = 1'b1;

        test_reset_state();
        test_reg_readback();
        test_status_unmapped();
        test_timestamp();
        test_back_pressure();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
